// ==== cpu_core.f ====
hw/cpu_pkg.sv
hw/insn_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/core_ctrl.sv
hw/cpu_core.sv
verif/cpu_core_tb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  alu_op_e         i_op,
    input  logic            i_type,
    input  logic [XLEN-1:0] i_x,
    input  logic [XLEN-1:0] i_y,
    input  logic [XLEN-1:0] i_imm,
    output logic [XLEN-1:0] o_rhs
);

    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] addend;
    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    // Type 0: (X op Y) + imm, type 1: (X op imm) + Y
    assign operand = i_type ? i_imm : i_y;
    assign addend  = i_type ? i_y   : i_imm;
    assign shamt   = operand[4:0];

    always_comb begin
        case (i_op)
            OP_OR:     result = i_x | operand;
            OP_AND:    result = i_x & operand;
            OP_ADD:    result = i_x + operand;
            OP_MUL:    result = i_x * operand;  // Low 32 bits of the product
            OP_RSVD:   result = '0;
            OP_SHL:    result = i_x << shamt;
            // Signed compares give all ones when true
            OP_CMP_LE: result = {XLEN{$signed(i_x) <= $signed(operand)}};
            OP_CMP_EQ: result = {XLEN{i_x == operand}};
            OP_NOR:    result = ~(i_x | operand);
            OP_NAND:   result = ~(i_x & operand);
            OP_XOR:    result = i_x ^ operand;
            OP_SUB:    result = i_x - operand;
            OP_XNOR:   result = i_x ^ ~operand;
            OP_SHR:    result = i_x >> shamt;   // Logical
            OP_CMP_GT: result = {XLEN{$signed(i_x) > $signed(operand)}};
            OP_CMP_NE: begin
                // Yields 1, not all ones
                result = {{(XLEN-1){1'b0}}, i_x != operand};
            end
            default:   result = '0;
        endcase
    end

    assign o_rhs = result + addend;

endmodule

// ==== hw/core_ctrl.sv ====
`timescale 1ns/1ns

module core_ctrl import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic                 i_reset_n,  // Clock
    input  logic                 i_reset,
    input  logic                 i_normal,
    input  logic                 i_illegal,
    input  deref_e               i_deref,
    input  logic [REG_IDX_W-1:0] i_idx_z,
    input  logic [XLEN-1:0]      i_z,
    input  logic [XLEN-1:0]      i_rhs,
    input  logic [XLEN-1:0]      i_mem_rdata,
    output logic [XLEN-1:0]      o_pc,
    output logic [XLEN-1:0]      o_insn_addr,
    output logic                 o_reg_we,
    output logic [XLEN-1:0]      o_reg_wdata,
    output logic [XLEN-1:0]      o_mem_addr,
    output logic [XLEN-1:0]      o_mem_wdata,
    output logic                 o_mem_we,
    output logic                 o_halt
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            halt_q;
    logic            active;
    logic            wb_reg;
    logic            jump;

    // Instruction executes only when normal, running and out of reset
    assign active = i_normal & ~halt_q & ~i_reset;

    // Register write-back for deref 00 and 01
    assign wb_reg      = active & ~i_deref[1];
    assign o_reg_wdata = (i_deref == REG_LOAD) ? i_mem_rdata : i_rhs;

    // Index 15 goes to the pc, index 0 is dropped
    assign jump     = wb_reg & (i_idx_z == REG_PC);
    assign o_reg_we = wb_reg & (i_idx_z != '0) & (i_idx_z != REG_PC);

    assign pc_next = jump ? o_reg_wdata : pc_q + 1;

    // Memory side, address is rhs except for stores through Z
    assign o_mem_addr  = (i_deref == STORE_AT_Z) ? i_z   : i_rhs;
    assign o_mem_wdata = (i_deref == STORE_AT_Z) ? i_rhs : i_z;
    assign o_mem_we    = active & i_deref[1];

    always_ff @(posedge i_reset_n) begin
        if (i_reset) begin
            pc_q   <= RESET_VECTOR;
            halt_q <= 1'b0;
        end else if (!halt_q) begin
            if (i_illegal) begin
                halt_q <= 1'b1;      // Sticky until reset, pc holds
            end else begin
                pc_q <= pc_next;     // No-ops also step here
            end
        end
    end

    assign o_pc = pc_q;

    // Halted core keeps fetching the reset vector
    assign o_insn_addr = halt_q ? RESET_VECTOR : pc_q;
    assign o_halt      = halt_q;

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic            i_reset_n,  // Clock
    input  logic            i_reset,
    output logic [XLEN-1:0] o_insn_addr,
    input  logic [XLEN-1:0] i_insn_data,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    output logic            o_mem_we,
    input  logic [XLEN-1:0] i_mem_rdata,
    output logic            o_halt
);

    logic [REG_IDX_W-1:0] idx_z;
    logic [REG_IDX_W-1:0] idx_x;
    logic [REG_IDX_W-1:0] idx_y;
    alu_op_e              op;
    deref_e               deref;
    logic                 op_type;
    logic [XLEN-1:0]      imm;
    logic                 normal;
    logic                 illegal;
    logic [XLEN-1:0]      val_x;
    logic [XLEN-1:0]      val_y;
    logic [XLEN-1:0]      val_z;
    logic [XLEN-1:0]      rhs;
    logic [XLEN-1:0]      pc;
    logic                 reg_we;
    logic [XLEN-1:0]      reg_wdata;

    insn_decoder decoder_i (
        .i_insn    (i_insn_data),
        .o_idx_z   (idx_z),
        .o_idx_x   (idx_x),
        .o_idx_y   (idx_y),
        .o_op      (op),
        .o_deref   (deref),
        .o_type    (op_type),
        .o_imm     (imm),
        .o_normal  (normal),
        .o_illegal (illegal)
    );

    reg_file regs_i (
        .i_reset_n (i_reset_n),
        .i_reset   (i_reset),
        .i_idx_x   (idx_x),
        .i_idx_y   (idx_y),
        .i_idx_z   (idx_z),
        .i_pc      (pc),
        .i_we      (reg_we),
        .i_wdata   (reg_wdata),
        .o_x       (val_x),
        .o_y       (val_y),
        .o_z       (val_z)
    );

    alu alu_i (
        .i_op   (op),
        .i_type (op_type),
        .i_x    (val_x),
        .i_y    (val_y),
        .i_imm  (imm),
        .o_rhs  (rhs)
    );

    core_ctrl #(
        .RESET_VECTOR (RESET_VECTOR)
    ) ctrl_i (
        .i_reset_n   (i_reset_n),
        .i_reset     (i_reset),
        .i_normal    (normal),
        .i_illegal   (illegal),
        .i_deref     (deref),
        .i_idx_z     (idx_z),
        .i_z         (val_z),
        .i_rhs       (rhs),
        .i_mem_rdata (i_mem_rdata),
        .o_pc        (pc),
        .o_insn_addr (o_insn_addr),
        .o_reg_we    (reg_we),
        .o_reg_wdata (reg_wdata),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_we    (o_mem_we),
        .o_halt      (o_halt)
    );

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath and address width
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 12;

    // Register 15 is the program counter
    localparam logic [REG_IDX_W-1:0] REG_PC = 4'd15;

    // ALU operations, encoded as insn[15:12]
    typedef enum logic [3:0] {
        OP_OR     = 4'h0,
        OP_AND    = 4'h1,
        OP_ADD    = 4'h2,
        OP_MUL    = 4'h3,
        OP_RSVD   = 4'h4,  // Gives zero before the addend
        OP_SHL    = 4'h5,
        OP_CMP_LE = 4'h6,
        OP_CMP_EQ = 4'h7,
        OP_NOR    = 4'h8,
        OP_NAND   = 4'h9,
        OP_XOR    = 4'hA,
        OP_SUB    = 4'hB,
        OP_XNOR   = 4'hC,
        OP_SHR    = 4'hD,
        OP_CMP_GT = 4'hE,
        OP_CMP_NE = 4'hF   // Only compare that yields 1 instead of all ones
    } alu_op_e;

    // Write-back modes, encoded as insn[29:28]
    // Bit 1 set means a memory store
    typedef enum logic [1:0] {
        REG_RHS      = 2'b00,  // Z <- rhs
        REG_LOAD     = 2'b01,  // Z <- [rhs]
        STORE_AT_Z   = 2'b10,  // [Z] <- rhs
        STORE_AT_RHS = 2'b11   // [rhs] <- Z
    } deref_e;

endpackage

// ==== hw/insn_decoder.sv ====
`timescale 1ns/1ns

module insn_decoder import cpu_pkg::*; (
    input  logic [XLEN-1:0]      i_insn,
    output logic [REG_IDX_W-1:0] o_idx_z,
    output logic [REG_IDX_W-1:0] o_idx_x,
    output logic [REG_IDX_W-1:0] o_idx_y,
    output alu_op_e              o_op,
    output deref_e               o_deref,
    output logic                 o_type,
    output logic [XLEN-1:0]      o_imm,
    output logic                 o_normal,
    output logic                 o_illegal
);

    logic [IMM_W-1:0] imm_raw;

    // Fixed field positions, decoded regardless of class
    assign o_type  = i_insn[30];
    assign o_deref = deref_e'(i_insn[29:28]);
    assign o_idx_z = i_insn[27:24];
    assign o_idx_x = i_insn[23:20];
    assign o_idx_y = i_insn[19:16];
    assign o_op    = alu_op_e'(i_insn[15:12]);
    assign imm_raw = i_insn[IMM_W-1:0];

    // Sign-extend the immediate to full width
    assign o_imm = {{(XLEN-IMM_W){imm_raw[IMM_W-1]}}, imm_raw};

    // Classification by the top nibble
    // 0xxx normal, 1111 illegal, anything else with bit 31 set is a no-op
    always_comb begin
        o_normal  = 1'b0;
        o_illegal = 1'b0;
        casez (i_insn[31:28])
            4'b0???: begin
                o_normal = 1'b1;
            end
            4'b1111: begin
                o_illegal = 1'b1;
            end
            default: begin
                o_normal = 1'b0;  // No-op
            end
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic                 i_reset_n,  // Clock
    input  logic                 i_reset,
    input  logic [REG_IDX_W-1:0] i_idx_x,
    input  logic [REG_IDX_W-1:0] i_idx_y,
    input  logic [REG_IDX_W-1:0] i_idx_z,
    input  logic [XLEN-1:0]      i_pc,
    input  logic                 i_we,
    input  logic [XLEN-1:0]      i_wdata,
    output logic [XLEN-1:0]      o_x,
    output logic [XLEN-1:0]      o_y,
    output logic [XLEN-1:0]      o_z
);

    // Only registers 1 to 14 hold state
    logic [XLEN-1:0] regs [1:14];

    function automatic logic [XLEN-1:0] read_reg(input logic [REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;            // Hardwired zero
        end else if (idx == REG_PC) begin
            return i_pc;          // Current instruction address
        end else begin
            return regs[idx];
        end
    endfunction

    assign o_x = read_reg(i_idx_x);
    assign o_y = read_reg(i_idx_y);
    assign o_z = read_reg(i_idx_z);

    // Controller never raises i_we for index 0 or 15
    always_ff @(posedge i_reset_n) begin
        if (i_reset) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_idx_z] <= i_wdata;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the cpu_core testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -f cpu_core.f --top-module cpu_core_tb \
    -o cpu_core_sim &&
./obj_dir/cpu_core_sim ||
exit 1

// ==== verif/cpu_core_tb.sv ====
`timescale 1ns/1ns

module cpu_core_tb import cpu_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_VECTOR = 32'd16;
    localparam int RANDOM_CYCLES = 600;
    localparam int HALT_CYCLES   = 24;
    localparam int RESET_CYCLES  = 3;
    localparam int RESET_COUNT   = 3;
    localparam int CLK_PERIOD    = 4;
    localparam int TOTAL_CYCLES  = RANDOM_CYCLES + HALT_CYCLES + RESET_COUNT * RESET_CYCLES;
    localparam int WATCHDOG_NS   = TOTAL_CYCLES * CLK_PERIOD + 100;

    logic            reset_n;  // Clock
    logic            reset;
    logic [XLEN-1:0] insn_addr;
    logic [XLEN-1:0] insn_data;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic            mem_we;
    logic [XLEN-1:0] mem_rdata;
    logic            halt;

    logic [XLEN-1:0] imem [0:255];
    logic [XLEN-1:0] dmem [0:255];

    // Reference model state
    logic [XLEN-1:0] m_regs [1:14];
    logic [XLEN-1:0] m_pc;
    logic            m_halt;
    logic [XLEN-1:0] m_dmem [0:255];
    logic            exp_we;
    logic [XLEN-1:0] exp_addr;
    logic [XLEN-1:0] exp_wdata;

    // Ideal memories, both aliased on the low address byte
    assign insn_data = imem[insn_addr[7:0]];
    assign mem_rdata = dmem[mem_addr[7:0]];

    cpu_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut_i (
        .i_reset_n   (reset_n),
        .i_reset     (reset),
        .o_insn_addr (insn_addr),
        .i_insn_data (insn_data),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_we    (mem_we),
        .i_mem_rdata (mem_rdata),
        .o_halt      (halt)
    );

    initial begin
        reset_n = 1'b0;
        forever #(CLK_PERIOD / 2) reset_n = ~reset_n;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the run completed");
        $display("test failed");
        $fatal(1, "timeout");
    end

    function automatic logic [XLEN-1:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5A, a + 8'h3C};
    endfunction

    function automatic logic [XLEN-1:0] make_insn(input logic op_type, input logic [1:0] deref,
                                                  input logic [3:0] z, input logic [3:0] x,
                                                  input logic [3:0] y, input logic [3:0] op,
                                                  input logic [11:0] imm);
        return {1'b0, op_type, deref, z, x, y, op, imm};
    endfunction

    // Mostly normal words, about one in eight a no-op, never illegal
    function automatic logic [XLEN-1:0] random_insn();
        logic [XLEN-1:0] w;
        w = $urandom;
        if (($urandom % 8) == 0) begin
            w[31] = 1'b1;
            if (w[30:28] == 3'b111) begin
                w[28] = 1'b0;
            end
        end else begin
            w[31] = 1'b0;
        end
        return w;
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [3:0] op, input logic op_type,
                                                input logic [XLEN-1:0] x,
                                                input logic [XLEN-1:0] y,
                                                input logic [11:0] imm12);
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        imm = {{20{imm12[11]}}, imm12};
        b   = op_type ? imm : y;
        case (op)
            4'h0: r = x | b;
            4'h1: r = x & b;
            4'h2: r = x + b;
            4'h3: r = x * b;
            4'h4: r = 32'd0;
            4'h5: r = x << b[4:0];
            4'h6: r = ($signed(x) <= $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
            4'h7: r = (x == b) ? 32'hFFFF_FFFF : 32'd0;
            4'h8: r = ~(x | b);
            4'h9: r = ~(x & b);
            4'hA: r = x ^ b;
            4'hB: r = x - b;
            4'hC: r = ~(x ^ b);
            4'hD: r = x >> b[4:0];
            4'hE: r = ($signed(x) > $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
            default: r = (x != b) ? 32'd1 : 32'd0;  // Not-equal gives 1
        endcase
        return r + (op_type ? y : imm);
    endfunction

    function automatic logic [XLEN-1:0] model_reg(input logic [3:0] idx);
        if (idx == 4'd0) begin
            return 32'd0;
        end else if (idx == 4'd15) begin
            return m_pc;
        end
        return m_regs[idx];
    endfunction

    // One instruction against the model, sets the expected store
    function automatic void step_model(input logic [XLEN-1:0] insn);
        logic [3:0]      iz;
        logic [XLEN-1:0] z;
        logic [XLEN-1:0] rhs;
        logic [XLEN-1:0] wb;
        exp_we    = 1'b0;
        exp_addr  = 32'd0;
        exp_wdata = 32'd0;
        iz  = insn[27:24];
        z   = model_reg(iz);
        rhs = alu_ref(insn[15:12], insn[30], model_reg(insn[23:20]),
                      model_reg(insn[19:16]), insn[11:0]);
        if (m_halt) begin
            return;
        end else if (insn[31:28] == 4'hF) begin
            m_halt = 1'b1;                     // pc holds
        end else if (insn[31]) begin
            m_pc = m_pc + 32'd1;
        end else if (!insn[29]) begin
            wb = insn[28] ? m_dmem[rhs[7:0]] : rhs;
            if (iz == 4'd15) begin
                m_pc = wb;                     // Jump
            end else begin
                if (iz != 4'd0) begin
                    m_regs[iz] = wb;
                end
                m_pc = m_pc + 32'd1;
            end
        end else begin
            exp_we    = 1'b1;
            exp_addr  = insn[28] ? rhs : z;
            exp_wdata = insn[28] ? z : rhs;
            m_dmem[exp_addr[7:0]] = exp_wdata;
            m_pc = m_pc + 32'd1;
        end
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic reset_model();
        m_pc   = RESET_VECTOR;
        m_halt = 1'b0;
        for (int r = 1; r <= 14; r++) begin
            m_regs[r[3:0]] = 32'd0;
        end
        for (int a = 0; a < 256; a++) begin
            m_dmem[a[7:0]] = fill_word(a[7:0]);
            dmem[a[7:0]] <= fill_word(a[7:0]);
        end
    endtask

    // Reset state shows from the first reset edge on
    task automatic apply_reset();
        reset <= 1'b1;
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(posedge reset_n);
            if (n < RESET_CYCLES - 1) begin
                @(negedge reset_n);
                check_value("o_insn_addr", RESET_VECTOR, insn_addr);
                check_value("o_halt", 32'd0, {31'd0, halt});
                check_value("o_mem_we", 32'd0, {31'd0, mem_we});
            end
        end
        reset <= 1'b0;
    endtask

    // Compare at the falling edge, then commit DUT stores on the rising edge
    task automatic run_cycles(input int count);
        logic [XLEN-1:0] fetch;
        logic            st_we;
        logic [XLEN-1:0] st_addr;
        logic [XLEN-1:0] st_data;
        for (int n = 0; n < count; n++) begin
            @(negedge reset_n);
            fetch = m_halt ? RESET_VECTOR : m_pc;
            check_value("o_insn_addr", fetch, insn_addr);
            check_value("o_halt", {31'd0, m_halt}, {31'd0, halt});
            step_model(imem[fetch[7:0]]);
            check_value("o_mem_we", {31'd0, exp_we}, {31'd0, mem_we});
            if (exp_we) begin
                check_value("o_mem_addr", exp_addr, mem_addr);
                check_value("o_mem_wdata", exp_wdata, mem_wdata);
            end
            st_we   = mem_we;
            st_addr = mem_addr;
            st_data = mem_wdata;
            @(posedge reset_n);
            if (st_we) begin
                dmem[st_addr[7:0]] <= st_data;
            end
        end
    endtask

    initial begin
        void'($urandom(53192));
        reset = 1'b1;
        for (int a = 0; a < 256; a++) begin
            imem[a[7:0]] <= random_insn();
        end
        reset_model();
        apply_reset();
        run_cycles(RANDOM_CYCLES);

        // Store of pc, no-op, jump to 22, then an illegal word
        imem[16] <= make_insn(1'b0, 2'd3, 4'd15, 4'd0, 4'd0, 4'h0, 12'd5);
        imem[17] <= 32'h8123_4567;
        imem[18] <= make_insn(1'b0, 2'd0, 4'd15, 4'd15, 4'd0, 4'h0, 12'd4);
        imem[22] <= 32'hF000_0000;
        reset_model();
        apply_reset();
        run_cycles(HALT_CYCLES);
        check_value("o_halt", 32'd1, {31'd0, halt});

        // Reset clears the halt
        apply_reset();

        $display("test passed");
        $finish;
    end

endmodule
